/* rtl/rename_settings.svh */
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// lanes renamed per cycle, lane 0 is the oldest
`define RENAME_WIDTH 4

// register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 64

// registers handed back by retirement per cycle
`define RETIRE_WIDTH 2

// physical registers left unmapped after reset
`define FREE_REGS (`PHYS_REGS - `ARCH_REGS)

`endif

/* rtl/rename_pkg.sv */
`include "rename_settings.svh"

package rename_pkg;

    ////////////////////
    // register numbers
    ////////////////////

    // architectural register number
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

    // physical register number
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;

    // free list occupancy, 0 up to FREE_REGS inclusive
    typedef logic [$clog2(`FREE_REGS + 1)-1:0] free_count_t;

endpackage

/* rtl/spec_map_table.sv */
`include "rename_settings.svh"

module spec_map_table import rename_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  logic                                 accept_i,
    input  arch_reg_t [`RENAME_WIDTH-1:0]        src1_areg_i,
    input  arch_reg_t [`RENAME_WIDTH-1:0]        src2_areg_i,
    input  arch_reg_t [`RENAME_WIDTH-1:0]        dest_areg_i,
    input  logic      [`RENAME_WIDTH-1:0]        dest_write_i,
    input  phys_reg_t [`RENAME_WIDTH-1:0]        new_preg_i,
    output phys_reg_t [`RENAME_WIDTH-1:0]        src1_preg_o,
    output phys_reg_t [`RENAME_WIDTH-1:0]        src2_preg_o,
    output phys_reg_t [`RENAME_WIDTH-1:0]        old_preg_o
);

    // one physical register per architectural register
    phys_reg_t map_q [`ARCH_REGS];

    ////////////////////
    // lookups
    ////////////////////

    // every lane sees the mapping from before this bundle,
    // the override stage fixes up intra-bundle dependencies
    always_comb
    begin
        for (int l = 0; l < `RENAME_WIDTH; l++)
        begin
            src1_preg_o[l] = map_q[src1_areg_i[l]];
            src2_preg_o[l] = map_q[src2_areg_i[l]];
            old_preg_o[l]  = map_q[dest_areg_i[l]];
        end
    end

    ////////////////////
    // bundle writes
    ////////////////////

    // lanes are walked oldest first so the youngest writer of a
    // register is the one left in the table
    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            // identity map, arch r lives in phys r
            for (int r = 0; r < `ARCH_REGS; r++)
            begin
                map_q[r] <= phys_reg_t'(r);
            end
        end
        else if (accept_i)
        begin
            for (int l = 0; l < `RENAME_WIDTH; l++)
            begin
                if (dest_write_i[l])
                begin
                    map_q[dest_areg_i[l]] <= new_preg_i[l];
                end
            end
        end
    end

endmodule

/* rtl/phys_free_list.sv */
`include "rename_settings.svh"

module phys_free_list import rename_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  logic                                 bundle_valid_i,
    input  logic      [`RENAME_WIDTH-1:0]        dest_write_i,
    input  logic      [`RETIRE_WIDTH-1:0]        free_valid_i,
    input  phys_reg_t [`RETIRE_WIDTH-1:0]        free_preg_i,
    output phys_reg_t [`RENAME_WIDTH-1:0]        new_preg_o,
    output logic                                 accept_o,
    output logic                                 rename_stall_o
);

    // the queue index wraps by overflow, so FREE_REGS is a power of two
    localparam int IDX_W      = $clog2(`FREE_REGS);
    localparam int LANE_CNT_W = $clog2(`RENAME_WIDTH + 1);
    localparam int REL_CNT_W  = $clog2(`RETIRE_WIDTH + 1);

    phys_reg_t             fl_q [`FREE_REGS];
    logic [IDX_W-1:0]      head_q;
    logic [IDX_W-1:0]      tail_q;
    free_count_t           count_q;

    logic [LANE_CNT_W-1:0] lane_off [`RENAME_WIDTH+1];
    logic [REL_CNT_W-1:0]  rel_off [`RETIRE_WIDTH+1];
    logic [LANE_CNT_W-1:0] alloc_cnt;
    logic [REL_CNT_W-1:0]  rel_cnt;
    free_count_t           taken_cnt;

    ////////////////////
    // allocation
    ////////////////////

    // prefix count of writing lanes gives each lane its queue slot
    always_comb
    begin
        lane_off[0] = '0;
        for (int l = 0; l < `RENAME_WIDTH; l++)
        begin
            lane_off[l+1] = lane_off[l] + LANE_CNT_W'(dest_write_i[l]);
        end
    end

    assign alloc_cnt = lane_off[`RENAME_WIDTH];

    always_comb
    begin
        for (int l = 0; l < `RENAME_WIDTH; l++)
        begin
            new_preg_o[l] = fl_q[head_q + IDX_W'(lane_off[l])];
        end
    end

    // only registers already queued at the start of the cycle count
    assign accept_o       = bundle_valid_i && (free_count_t'(alloc_cnt) <= count_q);
    assign rename_stall_o = bundle_valid_i && !accept_o;
    assign taken_cnt      = accept_o ? free_count_t'(alloc_cnt) : '0;

    ////////////////////
    // release
    ////////////////////

    // port 0 goes in first
    always_comb
    begin
        rel_off[0] = '0;
        for (int p = 0; p < `RETIRE_WIDTH; p++)
        begin
            rel_off[p+1] = rel_off[p] + REL_CNT_W'(free_valid_i[p]);
        end
    end

    assign rel_cnt = rel_off[`RETIRE_WIDTH];

    ////////////////////
    // queue state
    ////////////////////

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= free_count_t'(`FREE_REGS);
            // everything above the identity map starts free, ascending
            for (int i = 0; i < `FREE_REGS; i++)
            begin
                fl_q[i] <= phys_reg_t'(`ARCH_REGS + i);
            end
        end
        else
        begin
            for (int p = 0; p < `RETIRE_WIDTH; p++)
            begin
                if (free_valid_i[p])
                begin
                    fl_q[tail_q + IDX_W'(rel_off[p])] <= free_preg_i[p];
                end
            end
            tail_q  <= tail_q + IDX_W'(rel_cnt);
            head_q  <= head_q + IDX_W'(taken_cnt);
            count_q <= count_q - taken_cnt + free_count_t'(rel_cnt);
        end
    end

endmodule

/* rtl/bundle_override.sv */
`include "rename_settings.svh"

module bundle_override import rename_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  logic                                 accept_i,
    input  arch_reg_t [`RENAME_WIDTH-1:0]        src1_areg_i,
    input  arch_reg_t [`RENAME_WIDTH-1:0]        src2_areg_i,
    input  arch_reg_t [`RENAME_WIDTH-1:0]        dest_areg_i,
    input  logic      [`RENAME_WIDTH-1:0]        dest_write_i,
    input  phys_reg_t [`RENAME_WIDTH-1:0]        new_preg_i,
    input  phys_reg_t [`RENAME_WIDTH-1:0]        src1_preg_i,
    input  phys_reg_t [`RENAME_WIDTH-1:0]        src2_preg_i,
    input  phys_reg_t [`RENAME_WIDTH-1:0]        old_preg_i,
    output logic                                 out_valid_o,
    output phys_reg_t [`RENAME_WIDTH-1:0]        src1_preg_o,
    output phys_reg_t [`RENAME_WIDTH-1:0]        src2_preg_o,
    output phys_reg_t [`RENAME_WIDTH-1:0]        dest_preg_o,
    output phys_reg_t [`RENAME_WIDTH-1:0]        old_preg_o,
    output logic      [`RENAME_WIDTH-1:0]        dest_write_o
);

    // select of lane i: a value below i names that earlier lane,
    // the value i itself means the map table result
    localparam int SEL_W = $clog2(`RENAME_WIDTH);

    logic [`RENAME_WIDTH-1:0][SEL_W-1:0] rs1_sel_d;
    logic [`RENAME_WIDTH-1:0][SEL_W-1:0] rs2_sel_d;
    logic [`RENAME_WIDTH-1:0][SEL_W-1:0] rd_sel_d;

    logic                                out_valid_q;
    logic      [`RENAME_WIDTH-1:0]       dest_write_q;
    logic [`RENAME_WIDTH-1:0][SEL_W-1:0] rs1_sel_q;
    logic [`RENAME_WIDTH-1:0][SEL_W-1:0] rs2_sel_q;
    logic [`RENAME_WIDTH-1:0][SEL_W-1:0] rd_sel_q;
    phys_reg_t [`RENAME_WIDTH-1:0]       new_preg_q;
    phys_reg_t [`RENAME_WIDTH-1:0]       src1_preg_q;
    phys_reg_t [`RENAME_WIDTH-1:0]       src2_preg_q;
    phys_reg_t [`RENAME_WIDTH-1:0]       old_preg_q;

    ////////////////////
    // stage 0 compare
    ////////////////////

    // earlier lanes walked in order, the last match is the newest writer
    always_comb
    begin
        for (int i = 0; i < `RENAME_WIDTH; i++)
        begin
            rs1_sel_d[i] = SEL_W'(i);
            rs2_sel_d[i] = SEL_W'(i);
            rd_sel_d[i]  = SEL_W'(i);
            for (int j = 0; j < i; j++)
            begin
                if (dest_write_i[j] && (dest_areg_i[j] == src1_areg_i[i]))
                begin
                    rs1_sel_d[i] = SEL_W'(j);
                end
                if (dest_write_i[j] && (dest_areg_i[j] == src2_areg_i[i]))
                begin
                    rs2_sel_d[i] = SEL_W'(j);
                end
                if (dest_write_i[j] && (dest_areg_i[j] == dest_areg_i[i]))
                begin
                    rd_sel_d[i] = SEL_W'(j);
                end
            end
        end
    end

    ////////////////////
    // pipe registers
    ////////////////////

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            out_valid_q  <= 1'b0;
            dest_write_q <= '0;
        end
        else
        begin
            out_valid_q <= accept_i;
            if (accept_i)
            begin
                dest_write_q <= dest_write_i;
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (accept_i)
        begin
            rs1_sel_q   <= rs1_sel_d;
            rs2_sel_q   <= rs2_sel_d;
            rd_sel_q    <= rd_sel_d;
            new_preg_q  <= new_preg_i;
            src1_preg_q <= src1_preg_i;
            src2_preg_q <= src2_preg_i;
            old_preg_q  <= old_preg_i;
        end
    end

    ////////////////////
    // stage 1 override
    ////////////////////

    always_comb
    begin
        for (int i = 0; i < `RENAME_WIDTH; i++)
        begin
            src1_preg_o[i] = (rs1_sel_q[i] == SEL_W'(i)) ? src1_preg_q[i]
                                                         : new_preg_q[rs1_sel_q[i]];
            src2_preg_o[i] = (rs2_sel_q[i] == SEL_W'(i)) ? src2_preg_q[i]
                                                         : new_preg_q[rs2_sel_q[i]];
            old_preg_o[i]  = (rd_sel_q[i] == SEL_W'(i)) ? old_preg_q[i]
                                                        : new_preg_q[rd_sel_q[i]];
        end
    end

    assign out_valid_o  = out_valid_q;
    assign dest_preg_o  = new_preg_q;
    assign dest_write_o = dest_write_q;

endmodule

/* rtl/rename_top.sv */
`include "rename_settings.svh"

module rename_top import rename_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset_n,

    // decoded bundle
    input  logic                                 bundle_valid_i,
    input  arch_reg_t [`RENAME_WIDTH-1:0]        src1_areg_i,
    input  arch_reg_t [`RENAME_WIDTH-1:0]        src2_areg_i,
    input  arch_reg_t [`RENAME_WIDTH-1:0]        dest_areg_i,
    input  logic      [`RENAME_WIDTH-1:0]        dest_write_i,

    // registers freed at retirement
    input  logic      [`RETIRE_WIDTH-1:0]        free_valid_i,
    input  phys_reg_t [`RETIRE_WIDTH-1:0]        free_preg_i,

    output logic                                 rename_stall_o,

    // renamed bundle, one cycle after acceptance
    output logic                                 out_valid_o,
    output phys_reg_t [`RENAME_WIDTH-1:0]        src1_preg_o,
    output phys_reg_t [`RENAME_WIDTH-1:0]        src2_preg_o,
    output phys_reg_t [`RENAME_WIDTH-1:0]        dest_preg_o,
    output phys_reg_t [`RENAME_WIDTH-1:0]        old_preg_o,
    output logic      [`RENAME_WIDTH-1:0]        dest_write_o
);

    logic                                accept;
    phys_reg_t [`RENAME_WIDTH-1:0]       new_preg;
    phys_reg_t [`RENAME_WIDTH-1:0]       map_src1_preg;
    phys_reg_t [`RENAME_WIDTH-1:0]       map_src2_preg;
    phys_reg_t [`RENAME_WIDTH-1:0]       map_old_preg;

    ////////////////////
    // stage 0
    ////////////////////

    phys_free_list u_free_list (
        .clock          (clock),
        .reset_n        (reset_n),
        .bundle_valid_i (bundle_valid_i),
        .dest_write_i   (dest_write_i),
        .free_valid_i   (free_valid_i),
        .free_preg_i    (free_preg_i),
        .new_preg_o     (new_preg),
        .accept_o       (accept),
        .rename_stall_o (rename_stall_o)
    );

    spec_map_table u_map_table (
        .clock          (clock),
        .reset_n        (reset_n),
        .accept_i       (accept),
        .src1_areg_i    (src1_areg_i),
        .src2_areg_i    (src2_areg_i),
        .dest_areg_i    (dest_areg_i),
        .dest_write_i   (dest_write_i),
        .new_preg_i     (new_preg),
        .src1_preg_o    (map_src1_preg),
        .src2_preg_o    (map_src2_preg),
        .old_preg_o     (map_old_preg)
    );

    ////////////////////
    // stage 1
    ////////////////////

    bundle_override u_override (
        .clock          (clock),
        .reset_n        (reset_n),
        .accept_i       (accept),
        .src1_areg_i    (src1_areg_i),
        .src2_areg_i    (src2_areg_i),
        .dest_areg_i    (dest_areg_i),
        .dest_write_i   (dest_write_i),
        .new_preg_i     (new_preg),
        .src1_preg_i    (map_src1_preg),
        .src2_preg_i    (map_src2_preg),
        .old_preg_i     (map_old_preg),
        .out_valid_o    (out_valid_o),
        .src1_preg_o    (src1_preg_o),
        .src2_preg_o    (src2_preg_o),
        .dest_preg_o    (dest_preg_o),
        .old_preg_o     (old_preg_o),
        .dest_write_o   (dest_write_o)
    );

endmodule

/* verif/rename_tb.sv */
`include "rename_settings.svh"

module rename_tb import rename_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LANES        = `RENAME_WIDTH;
    localparam int FIELDS       = 34;
    localparam int RESET_CYCLES = 16;
    localparam int RESET_WAIT   = 20;
    localparam int MAX_LINES    = 500;

    // trace columns
    localparam int F_VALID = 0;
    localparam int F_WRITE = 1;
    localparam int F_LANE  = 2;
    localparam int F_FREE  = 14;
    localparam int F_STALL = 17;
    localparam int F_EXP   = 18;

    logic                               clock;
    logic                               reset_n;
    logic                               bundle_valid_i;
    arch_reg_t [LANES-1:0]              src1_areg_i;
    arch_reg_t [LANES-1:0]              src2_areg_i;
    arch_reg_t [LANES-1:0]              dest_areg_i;
    logic      [LANES-1:0]              dest_write_i;
    logic      [`RETIRE_WIDTH-1:0]      free_valid_i;
    phys_reg_t [`RETIRE_WIDTH-1:0]      free_preg_i;
    logic                               rename_stall_o;
    logic                               out_valid_o;
    phys_reg_t [LANES-1:0]              src1_preg_o;
    phys_reg_t [LANES-1:0]              src2_preg_o;
    phys_reg_t [LANES-1:0]              dest_preg_o;
    phys_reg_t [LANES-1:0]              old_preg_o;
    logic      [LANES-1:0]              dest_write_o;

    int                                 fd;
    int                                 field [FIELDS];
    int                                 prev_field [FIELDS];
    logic                               prev_accepted;
    logic [8*128-1:0]                   line_buf;

    rename_top dut (
        .clock          (clock),
        .reset_n        (reset_n),
        .bundle_valid_i (bundle_valid_i),
        .src1_areg_i    (src1_areg_i),
        .src2_areg_i    (src2_areg_i),
        .dest_areg_i    (dest_areg_i),
        .dest_write_i   (dest_write_i),
        .free_valid_i   (free_valid_i),
        .free_preg_i    (free_preg_i),
        .rename_stall_o (rename_stall_o),
        .out_valid_o    (out_valid_o),
        .src1_preg_o    (src1_preg_o),
        .src2_preg_o    (src2_preg_o),
        .dest_preg_o    (dest_preg_o),
        .old_preg_o     (old_preg_o),
        .dest_write_o   (dest_write_o)
    );

    always #50 clock = ~clock;

    task abort_run();
        $display("Result: FAILED");
        $fatal(1, "rename testbench stopped on error");
    endtask

    task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("mismatch at %0d ns: %s is %0d, expected %0d", $time, name, actual,
                     expected);
            abort_run();
        end
    endtask

    ////////////////////
    // trace reading
    ////////////////////

    // lines that start with # hold column notes and are skipped
    task read_line(output bit got);
        int code;
        int value;
        int skipped;
        got = 1'b0;
        skipped = 0;
        code = $fscanf(fd, "%d", value);
        while (code == 0)
        begin
            skipped++;
            if (skipped > MAX_LINES)
            begin
                $display("trace file holds no readable data after %0d lines", skipped);
                abort_run();
            end
            code = $fgets(line_buf, fd);
            code = $fscanf(fd, "%d", value);
        end
        if (code == 1)
        begin
            field[0] = value;
            for (int i = 1; i < FIELDS; i++)
            begin
                code = $fscanf(fd, "%d", value);
                if (code != 1)
                begin
                    $display("trace line ends after %0d of %0d columns", i, FIELDS);
                    abort_run();
                end
                field[i] = value;
            end
            got = 1'b1;
        end
    endtask

    ////////////////////
    // drive and check
    ////////////////////

    task drive_line();
        arch_reg_t [LANES-1:0] rs1;
        arch_reg_t [LANES-1:0] rs2;
        arch_reg_t [LANES-1:0] rd;
        for (int l = 0; l < LANES; l++)
        begin
            rs1[l] = arch_reg_t'(field[F_LANE + 3*l]);
            rs2[l] = arch_reg_t'(field[F_LANE + 3*l + 1]);
            rd[l]  = arch_reg_t'(field[F_LANE + 3*l + 2]);
        end
        bundle_valid_i <= field[F_VALID][0];
        src1_areg_i    <= rs1;
        src2_areg_i    <= rs2;
        dest_areg_i    <= rd;
        dest_write_i   <= field[F_WRITE][LANES-1:0];
        free_valid_i   <= field[F_FREE][`RETIRE_WIDTH-1:0];
        free_preg_i[0] <= phys_reg_t'(field[F_FREE + 1]);
        free_preg_i[1] <= phys_reg_t'(field[F_FREE + 2]);
    endtask

    // outputs belong to the bundle accepted one edge earlier
    task check_outputs();
        for (int l = 0; l < LANES; l++)
        begin
            check_value($sformatf("src1_preg_o[%0d]", l), src1_preg_o[l],
                        prev_field[F_EXP + 4*l]);
            check_value($sformatf("src2_preg_o[%0d]", l), src2_preg_o[l],
                        prev_field[F_EXP + 4*l + 1]);
            if (prev_field[F_WRITE][l])
            begin
                check_value($sformatf("dest_preg_o[%0d]", l), dest_preg_o[l],
                            prev_field[F_EXP + 4*l + 2]);
            end
            check_value($sformatf("old_preg_o[%0d]", l), old_preg_o[l],
                        prev_field[F_EXP + 4*l + 3]);
            check_value($sformatf("dest_write_o[%0d]", l), dest_write_o[l],
                        prev_field[F_WRITE][l]);
        end
    endtask

    task run_cycle();
        @(posedge clock);
        drive_line();
        @(negedge clock);
        check_value("rename_stall_o", rename_stall_o, field[F_STALL]);
        check_value("out_valid_o", out_valid_o, prev_accepted);
        if (prev_accepted)
        begin
            check_outputs();
        end
        prev_field    = field;
        prev_accepted = (field[F_VALID] != 0) && (field[F_STALL] == 0);
    endtask

    initial
    begin
        bit got;
        int wait_cycles;
        int line_count;
        clock          = 1'b0;
        reset_n        = 1'b0;
        bundle_valid_i = 1'b0;
        src1_areg_i    = '0;
        src2_areg_i    = '0;
        dest_areg_i    = '0;
        dest_write_i   = '0;
        free_valid_i   = '0;
        free_preg_i    = '0;
        prev_accepted  = 1'b0;
        foreach (field[i])
        begin
            field[i] = 0;
        end
        for (int c = 0; c < RESET_CYCLES; c++)
        begin
            @(posedge clock);
        end
        reset_n <= 1'b1;

        wait_cycles = 0;
        while (reset_n !== 1'b1 || out_valid_o !== 1'b0 || rename_stall_o !== 1'b0)
        begin
            @(posedge clock);
            wait_cycles++;
            if (wait_cycles > RESET_WAIT)
            begin
                $display("DUT outputs did not settle after reset release");
                abort_run();
            end
        end

        fd = $fopen("verif/rename_trace.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the trace file verif/rename_trace.txt");
            abort_run();
        end

        line_count = 0;
        read_line(got);
        while (got)
        begin
            run_cycle();
            line_count++;
            if (line_count > MAX_LINES)
            begin
                $display("trace did not end within %0d lines", MAX_LINES);
                abort_run();
            end
            read_line(got);
        end
        $fclose(fd);

        // one idle cycle to see the last bundle come out
        foreach (field[i])
        begin
            field[i] = 0;
        end
        run_cycle();

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* verif/rename_trace.txt */
# v wmask | rs1 rs2 rd for lanes 0..3 | free mask, preg0, preg1 | stall
# expected | src1 src2 dest old for lanes 0..3, all zero when not accepted
1 0 1 2 3 4 5 6 7 8 9 10 11 12 0 0 0 0 1 2 0 3 4 5 0 6 7 8 0 9 10 11 0 12
1 5 1 2 3 4 5 6 7 8 9 10 11 12 0 0 0 0 1 2 32 3 4 5 0 6 7 8 33 9 10 11 0 12
1 15 3 9 5 5 3 5 5 1 1 1 5 7 0 0 0 0 32 33 34 5 34 32 35 34 35 1 36 1 36 35 37 7
1 0 5 1 7 3 9 3 0 2 4 6 8 10 0 0 0 0 35 36 0 37 32 33 0 32 0 2 0 4 6 8 0 10
1 15 10 11 20 12 13 21 14 15 22 16 17 23 0 0 0 0 10 11 38 20 12 13 39 21 14 15 40 22 16 17 41 23
1 15 20 21 20 22 23 21 20 21 22 22 20 23 0 0 0 0 38 39 42 38 40 41 43 39 42 43 44 40 44 42 45 41
1 15 20 21 24 22 23 25 24 25 26 26 24 27 0 0 0 0 42 43 46 24 44 45 47 25 46 47 48 26 48 46 49 27
1 15 24 25 28 26 27 29 28 0 30 29 30 31 0 0 0 0 46 47 50 28 48 49 51 29 50 0 52 30 51 52 53 31
1 15 31 28 20 20 2 20 4 6 21 21 20 21 0 0 0 0 53 50 54 42 54 2 55 54 4 6 56 43 56 55 57 56
1 11 20 21 22 22 0 23 23 22 24 24 23 25 0 0 0 0 55 57 58 44 58 0 59 45 59 58 0 46 46 59 60 47
1 15 1 2 3 3 5 6 6 7 8 8 9 10 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 15 1 2 3 3 5 6 6 7 8 8 9 10 3 3 9 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 15 1 2 3 3 5 6 6 7 8 8 9 10 0 0 0 0 36 2 61 32 61 35 62 6 62 37 63 8 63 33 3 10
1 1 10 3 11 11 12 13 0 0 0 1 1 1 3 5 1 0 3 61 9 11 9 12 0 13 0 0 0 0 36 36 0 36
1 15 11 13 14 14 15 16 16 14 14 17 18 19 2 0 7 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 15 11 13 14 14 15 16 16 14 14 17 18 19 3 10 8 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 15 11 13 14 14 15 16 16 14 14 17 18 19 0 0 0 0 9 13 5 14 5 15 1 16 1 5 7 5 17 18 10 19
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 14 16 19 0 0 0 2 2 2 4 4 4 0 0 0 0 7 1 8 10 0 0 0 0 2 2 0 2 4 4 0 4
1 1 12 12 12 0 0 0 0 0 0 0 0 0 1 14 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 12 12 12 0 0 0 0 0 0 0 0 0 0 0 0 0 12 12 14 12 0 0 0 0 0 0 0 0 0 0 0 0

/* vlog.f */
+incdir+rtl
rtl/rename_pkg.sv
rtl/spec_map_table.sv
rtl/phys_free_list.sv
rtl/bundle_override.sv
rtl/rename_top.sv
verif/rename_tb.sv

/* Bender.yml */
package:
  name: rename_stage

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/rename_pkg.sv
      - rtl/spec_map_table.sv
      - rtl/phys_free_list.sv
      - rtl/bundle_override.sv
      - rtl/rename_top.sv
  - target: simulation
    files:
      - verif/rename_tb.sv
